// ==== all.f ====
+incdir+verification
hdl/nlc_pkg.sv
hdl/nlc_capture.sv
hdl/nlc_channel_engine.sv
hdl/nlc_output_collect.sv
hdl/nlc_top.sv
verification/nlc_tb.sv

// ==== hdl/nlc_capture.sv ====
// Strobes during a run are dropped; the coefficient bank loads only in MODE_LOAD_COEFF
`timescale 1ns/1ps

module nlc_capture import nlc_pkg::*; #(
	parameter int NUM_CH = 16
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       srdyi_i,
	input  nlc_mode_e  mode_i,
	input  sample_t    x_adc_i [NUM_CH],
	input  chan_cal_t  cal_i [NUM_CH],
	input  coeff_set_t coeff_i [NUM_CH],
	input  logic       done_i,
	output logic       start_o,
	output sample_t    sample_o [NUM_CH],
	output chan_cal_t  cal_o [NUM_CH],
	output coeff_set_t coeff_o [NUM_CH]
);

	logic busy;
	logic accept;
	logic load_coeff;

	// A strobe only counts when no run is in flight
	assign accept = srdyi_i && !busy;
	assign load_coeff = accept && (mode_i == MODE_LOAD_COEFF);

	always_ff @(posedge clk) begin
		if (reset) begin
			start_o <= 1'b0;
			busy <= 1'b0;
		end else begin
			start_o <= accept;
			if (accept) begin
				busy <= 1'b1;
			end else if (done_i) begin
				busy <= 1'b0;
			end
		end
	end

	// Sample and calibration banks, refreshed on every accepted strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int ch = 0; ch < NUM_CH; ch++) begin
				sample_o[ch] <= '0;
				cal_o[ch] <= '0;
			end
		end else if (accept) begin
			for (int ch = 0; ch < NUM_CH; ch++) begin
				sample_o[ch] <= x_adc_i[ch];
				cal_o[ch] <= cal_i[ch];
			end
		end
	end

	// Coefficient bank survives runs in the stored modes
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int ch = 0; ch < NUM_CH; ch++) begin
				coeff_o[ch] <= '0;
			end
		end else if (load_coeff) begin
			for (int ch = 0; ch < NUM_CH; ch++) begin
				coeff_o[ch] <= coeff_i[ch];
			end
		end
	end

	start_single_cycle: assert property (
		@(posedge clk) disable iff (reset)
		start_o |=> !start_o
	) else $error("start_o held high for two cycles");

	// Engine completion must belong to a run this block started
	done_while_busy: assert property (
		@(posedge clk) disable iff (reset)
		done_i |-> busy
	) else $error("done_i arrived with no run in flight");

endmodule

// ==== hdl/nlc_channel_engine.sv ====
// Fixed seven-step latency per run; start must not arrive while a run is in progress
`timescale 1ns/1ps

module nlc_channel_engine import nlc_pkg::*; #(
	parameter int FRAC_BITS = 16
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       start_i,
	input  sample_t    sample_i,
	input  chan_cal_t  cal_i,
	input  coeff_set_t coeff_i,
	output word_t      result_o,
	output logic       done_o
);

	localparam int STEP_W = 3;

	// Step values match the cycle count after start
	localparam logic [STEP_W-1:0] STEP_IDLE      = 3'd0;
	localparam logic [STEP_W-1:0] STEP_SCALE     = 3'd1;
	localparam logic [STEP_W-1:0] STEP_FIRST_MAC = 3'd2;
	localparam logic [STEP_W-1:0] STEP_LAST_MAC  = 3'd6;
	localparam logic [STEP_W-1:0] STEP_DONE      = 3'd7;

	logic [STEP_W-1:0] step;
	logic [STEP_W-1:0] coeff_idx;
	logic              mac_step;

	word_t sample_ext;
	word_t diff;
	word_t z;
	word_t acc;

	// Shared multiplier operands and result
	word_t mul_a;
	word_t mul_b;
	prod_t product;
	prod_t product_shift;
	word_t mul_res;
	word_t addend;

	assign sample_ext = {{(WORD_W-SAMPLE_W){sample_i[SAMPLE_W-1]}}, sample_i};

	assign mac_step = (step >= STEP_FIRST_MAC) && (step <= STEP_LAST_MAC);

	// Step 2 adds coefficient 4, step 6 adds coefficient 0
	assign coeff_idx = STEP_W'(COEFF_COUNT) - step;

	always_comb begin
		mul_a = acc;
		mul_b = z;
		addend = '0;
		if (step == STEP_SCALE) begin
			mul_a = diff;
			mul_b = cal_i.recip_stdev;
		end else if (step == STEP_FIRST_MAC) begin
			// Horner starts from the top coefficient
			mul_a = coeff_i[COEFF_COUNT-1];
		end
		if (mac_step) begin
			addend = coeff_i[coeff_idx];
		end
	end

	assign product = mul_a * mul_b;
	assign product_shift = product >>> FRAC_BITS;
	assign mul_res = product_shift[WORD_W-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			step <= STEP_IDLE;
		end else if (start_i) begin
			step <= STEP_SCALE;
		end else if (step == STEP_DONE) begin
			step <= STEP_IDLE;
		end else if (step != STEP_IDLE) begin
			step <= step + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			diff <= '0;
			z <= '0;
			acc <= '0;
		end else begin
			if (start_i) begin
				diff <= sample_ext + cal_i.neg_mean;
			end
			if (step == STEP_SCALE) begin
				z <= mul_res;
			end
			if (mac_step) begin
				acc <= mul_res + addend;
			end
		end
	end

	assign result_o = acc;
	assign done_o = (step == STEP_DONE);

	// The capture block must hold off new strobes until the run ends
	start_when_idle: assert property (
		@(posedge clk) disable iff (reset)
		start_i |-> (step == STEP_IDLE)
	) else $error("start_i arrived while the engine was running");

endmodule

// ==== hdl/nlc_output_collect.sv ====
// Results are truncated to the low SAMPLE_W bits and held until the next done pulse
`timescale 1ns/1ps

module nlc_output_collect import nlc_pkg::*; #(
	parameter int NUM_CH = 16
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    done_i,
	input  word_t   result_i [NUM_CH],
	output sample_t x_lin_o [NUM_CH],
	output logic    srdyo_o
);

	always_ff @(posedge clk) begin
		if (reset) begin
			srdyo_o <= 1'b0;
		end else begin
			srdyo_o <= done_i;
		end
	end

	// Output bank changes only at the end of a run
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int ch = 0; ch < NUM_CH; ch++) begin
				x_lin_o[ch] <= '0;
			end
		end else if (done_i) begin
			for (int ch = 0; ch < NUM_CH; ch++) begin
				x_lin_o[ch] <= result_i[ch][SAMPLE_W-1:0];
			end
		end
	end

	// Runs are at least eight cycles apart, so the strobe can never repeat
	srdyo_single_cycle: assert property (
		@(posedge clk) disable iff (reset)
		srdyo_o |=> !srdyo_o
	) else $error("srdyo_o high two cycles in a row");

endmodule

// ==== hdl/nlc_pkg.sv ====
// Widths and fixed-point types shared by the corrector; only mode 00 changes behavior
package nlc_pkg;

	// ADC sample and corrected output width
	localparam int SAMPLE_W = 21;

	// Fixed-point arithmetic word width
	localparam int WORD_W = 32;

	// Polynomial coefficients, orders 0 to 5
	localparam int COEFF_COUNT = 6;

	// Full product width before the fraction shift
	localparam int PROD_W = 2 * WORD_W;

	// Sample shares the word's fraction position, so it is used sign-extended
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	typedef logic signed [WORD_W-1:0] word_t;

	typedef logic signed [PROD_W-1:0] prod_t;

	// Per-channel normalization values
	typedef struct packed {
		word_t neg_mean;
		word_t recip_stdev;
	} chan_cal_t;

	// Indexed by polynomial order
	typedef word_t [COEFF_COUNT-1:0] coeff_set_t;

	// Modes 01 and 10 evaluate with the stored bank, like 11
	typedef enum logic [1:0] {
		MODE_LOAD_COEFF = 2'b00,
		MODE_UPGRADE    = 2'b01,
		MODE_FIT_ERROR  = 2'b10,
		MODE_STORED     = 2'b11
	} nlc_mode_e;

endpackage

// ==== hdl/nlc_top.sv ====
// Result strobe follows an accepted input strobe by nine edges; no back-pressure
`timescale 1ns/1ps

module nlc_top import nlc_pkg::*; #(
	parameter int NUM_CH    = 16,
	parameter int FRAC_BITS = 16
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       srdyi_i,
	input  nlc_mode_e  mode_i,
	input  sample_t    x_adc_i [NUM_CH],
	input  chan_cal_t  cal_i [NUM_CH],
	input  coeff_set_t coeff_i [NUM_CH],
	output sample_t    x_lin_o [NUM_CH],
	output logic       srdyo_o
);

	logic       start;
	sample_t    sample_q [NUM_CH];
	chan_cal_t  cal_q [NUM_CH];
	coeff_set_t coeff_q [NUM_CH];
	word_t      result [NUM_CH];

	// Engines run in lockstep; engine 0 speaks for all of them
	logic [NUM_CH-1:0] done_vec;

	nlc_capture #(
		.NUM_CH(NUM_CH)
	) capture_i (
		.clk(clk),
		.reset(reset),
		.srdyi_i(srdyi_i),
		.mode_i(mode_i),
		.x_adc_i(x_adc_i),
		.cal_i(cal_i),
		.coeff_i(coeff_i),
		.done_i(done_vec[0]),
		.start_o(start),
		.sample_o(sample_q),
		.cal_o(cal_q),
		.coeff_o(coeff_q)
	);

	for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_engine
		nlc_channel_engine #(
			.FRAC_BITS(FRAC_BITS)
		) engine_i (
			.clk(clk),
			.reset(reset),
			.start_i(start),
			.sample_i(sample_q[ch]),
			.cal_i(cal_q[ch]),
			.coeff_i(coeff_q[ch]),
			.result_o(result[ch]),
			.done_o(done_vec[ch])
		);
	end

	nlc_output_collect #(
		.NUM_CH(NUM_CH)
	) collect_i (
		.clk(clk),
		.reset(reset),
		.done_i(done_vec[0]),
		.result_i(result),
		.x_lin_o(x_lin_o),
		.srdyo_o(srdyo_o)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the corrector testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
	--top-module nlc_tb \
	-f all.f \
	-o nlc_sim

./obj_dir/nlc_sim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

// ==== verification/nlc_tb_model.svh ====
// Included inside nlc_tb only; relies on its FRAC_BITS, lfsr_state and error counters
`ifndef NLC_TB_MODEL_SVH
`define NLC_TB_MODEL_SVH

// Signed product, arithmetic shift by the fraction bits, low word kept
function automatic word_t fx_mul(input word_t a, input word_t b);
	prod_t p;
	p = prod_t'(a) * prod_t'(b);
	p = p >>> FRAC_BITS;
	return p[WORD_W-1:0];
endfunction

// Normalize, then Horner from order 5 down to 0, truncated to the sample width
function automatic sample_t model_channel(input sample_t s, input chan_cal_t cal,
		input coeff_set_t c);
	word_t diff;
	word_t z;
	word_t acc;
	diff = {{(WORD_W-SAMPLE_W){s[SAMPLE_W-1]}}, s} + cal.neg_mean;
	z = fx_mul(diff, cal.recip_stdev);
	acc = c[COEFF_COUNT-1];
	for (int o = COEFF_COUNT - 2; o >= 0; o--) begin
		acc = fx_mul(acc, z) + c[o];
	end
	return acc[SAMPLE_W-1:0];
endfunction

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic fb;
	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		r = {r[30:0], lfsr_state[0]};
	end
	return r;
endfunction

// Sign-extended from the top bit taken
function automatic word_t rand_signed(input int bits);
	word_t v;
	v = rand_bits(bits) << (WORD_W - bits);
	v = v >>> (WORD_W - bits);
	return v;
endfunction

task automatic check_sample(input string name, input sample_t exp, input sample_t act);
	if (act !== exp) begin
		value_errors++;
		$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		value_errors++;
		$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
	end
endtask

task automatic check_count(input string name, input int exp, input int act);
	if (act != exp) begin
		value_errors++;
		$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
	end
endtask

`endif

// ==== verification/nlc_tb.sv ====
// Directed tests at the default parameters; a run takes nine edges from strobe to result
`timescale 1ns/1ps

module nlc_tb import nlc_pkg::*; ();

	localparam int NUM_CH = 16;
	localparam int FRAC_BITS = 16;
	localparam int RUN_LATENCY = 9;
	localparam int RESULT_TIMEOUT = 20;
	localparam int NUM_RUNS = 8;
	localparam int WATCHDOG_CYCLES = NUM_RUNS * 20 + 40;

	logic       clk;
	logic       reset;
	logic       srdyi;
	nlc_mode_e  mode_in;
	sample_t    x_adc [NUM_CH];
	chan_cal_t  cal_in [NUM_CH];
	coeff_set_t coeff_in [NUM_CH];
	sample_t    x_lin [NUM_CH];
	logic       srdyo;

	// Model copy of the coefficient bank inside the DUT
	coeff_set_t bank [NUM_CH];
	sample_t    expected [NUM_CH];

	logic [31:0] lfsr_state;
	int          value_errors;
	int          missing_results;

	`include "nlc_tb_model.svh"

	nlc_top dut_i (
		.clk(clk),
		.reset(reset),
		.srdyi_i(srdyi),
		.mode_i(mode_in),
		.x_adc_i(x_adc),
		.cal_i(cal_in),
		.coeff_i(coeff_in),
		.x_lin_o(x_lin),
		.srdyo_o(srdyo)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic compute_expected(input nlc_mode_e mode);
		for (int ch = 0; ch < NUM_CH; ch++) begin
			if (mode == MODE_LOAD_COEFF) begin
				bank[ch] = coeff_in[ch];
			end
			expected[ch] = model_channel(x_adc[ch], cal_in[ch], bank[ch]);
		end
	endtask

	// Samples and mean within 8.0, scale below 1.0, coefficients within 2.0
	task automatic drive_strobe(input nlc_mode_e mode, input bit update_model);
		mode_in = mode;
		for (int ch = 0; ch < NUM_CH; ch++) begin
			x_adc[ch] = sample_t'(rand_signed(20));
			cal_in[ch].neg_mean = rand_signed(20);
			cal_in[ch].recip_stdev = word_t'(rand_bits(16));
			for (int o = 0; o < COEFF_COUNT; o++) begin
				coeff_in[ch][o] = rand_signed(18);
			end
		end
		if (update_model) begin
			compute_expected(mode);
		end
		srdyi = 1'b1;
	endtask

	task automatic send_strobe(input nlc_mode_e mode, input bit update_model);
		@(posedge clk);
		#1;
		drive_strobe(mode, update_model);
		@(posedge clk);
		#1;
		srdyi = 1'b0;
	endtask

	// Counts falling edges until the result strobe shows up
	task automatic wait_result(input string name, output int latency);
		int count;
		bit seen;
		count = 0;
		seen = 1'b0;
		latency = -1;
		while (!seen && count < RESULT_TIMEOUT) begin
			@(negedge clk);
			count++;
			if (srdyo) begin
				seen = 1'b1;
			end
		end
		if (seen) begin
			latency = count;
		end else begin
			missing_results++;
			$display("%s: no result strobe within %0d cycles", name, RESULT_TIMEOUT);
		end
	endtask

	task automatic check_outputs(input string name);
		for (int ch = 0; ch < NUM_CH; ch++) begin
			check_sample($sformatf("%s ch%0d", name, ch), expected[ch], x_lin[ch]);
		end
	endtask

	task automatic run_and_check(input string name, input nlc_mode_e mode);
		int latency;
		send_strobe(mode, 1'b1);
		wait_result(name, latency);
		if (latency > 0) begin
			check_count($sformatf("%s latency", name), RUN_LATENCY, latency);
			@(negedge clk);
			check_bit($sformatf("%s strobe width", name), 1'b0, srdyo);
			check_outputs(name);
		end
	endtask

	task automatic test_reset_state();
		repeat (3) begin
			@(negedge clk);
			check_bit("reset_state srdyo", 1'b0, srdyo);
			for (int ch = 0; ch < NUM_CH; ch++) begin
				check_sample($sformatf("reset_state ch%0d", ch), '0, x_lin[ch]);
			end
		end
	endtask

	task automatic test_load_coeff();
		run_and_check("load_coeff", MODE_LOAD_COEFF);
	endtask

	task automatic test_stored_coeff();
		run_and_check("stored_coeff", MODE_STORED);
	endtask

	task automatic test_dropped_modes();
		run_and_check("mode_upgrade", MODE_UPGRADE);
		run_and_check("mode_fit_error", MODE_FIT_ERROR);
	endtask

	task automatic test_busy_strobe();
		int latency;
		int extra;
		send_strobe(MODE_LOAD_COEFF, 1'b1);
		@(posedge clk);
		// Lands three edges after the first strobe and must not load its coefficients
		send_strobe(MODE_LOAD_COEFF, 1'b0);
		wait_result("busy_strobe", latency);
		if (latency > 0) begin
			check_count("busy_strobe latency", RUN_LATENCY - 3, latency);
			check_outputs("busy_strobe");
			extra = 0;
			repeat (12) begin
				@(negedge clk);
				if (srdyo) begin
					extra++;
				end
			end
			check_count("busy_strobe extra pulses", 0, extra);
		end
	endtask

	task automatic test_outputs_hold();
		int latency;
		run_and_check("hold_run", MODE_STORED);
		repeat (20) begin
			@(negedge clk);
			check_bit("hold srdyo", 1'b0, srdyo);
			for (int ch = 0; ch < NUM_CH; ch++) begin
				check_sample($sformatf("hold ch%0d", ch), expected[ch], x_lin[ch]);
			end
		end
		send_strobe(MODE_LOAD_COEFF, 1'b1);
		// Next strobe sits in the cycle where the first result strobe is high
		repeat (RUN_LATENCY - 1) @(posedge clk);
		#1;
		drive_strobe(MODE_STORED, 1'b0);
		@(negedge clk);
		check_bit("back_to_back first srdyo", 1'b1, srdyo);
		check_outputs("back_to_back first");
		compute_expected(MODE_STORED);
		@(posedge clk);
		#1;
		srdyi = 1'b0;
		wait_result("back_to_back second", latency);
		if (latency > 0) begin
			check_count("back_to_back second latency", RUN_LATENCY, latency);
			@(negedge clk);
			check_bit("back_to_back second strobe width", 1'b0, srdyo);
			check_outputs("back_to_back second");
		end
	endtask

	initial begin
		lfsr_state = 32'h6e06;
		value_errors = 0;
		missing_results = 0;
		reset = 1'b1;
		srdyi = 1'b0;
		mode_in = MODE_STORED;
		for (int ch = 0; ch < NUM_CH; ch++) begin
			x_adc[ch] = '0;
			cal_in[ch] = '0;
			coeff_in[ch] = '0;
			bank[ch] = '0;
			expected[ch] = '0;
		end
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		test_reset_state();
		test_load_coeff();
		test_stored_coeff();
		test_dropped_modes();
		test_busy_strobe();
		test_outputs_hold();

		$display("Errors: %0d value mismatches, %0d missing result strobes",
			value_errors, missing_results);
		if (value_errors == 0 && missing_results == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the tests did not finish",
			WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
